// File: rename_unit.f
+incdir+design
design/rename_types_pkg.sv
design/riscv_instr_pkg.sv
design/free_list.sv
design/rename_table.sv
design/rename_unit.sv
testbench/tb_rename_unit.sv

// File: testbench/tb_rename_unit.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the rename stage, table of rows applied in a loop
// with expected values from a shadow map and free order model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rename_settings.svh"

module tb_rename_unit;
    import rename_types_pkg::*;
    import riscv_instr_pkg::*;

    localparam int RST_LIMIT = 20;            // Cycles allowed for reset release

    typedef struct packed {
        logic             valid;
        logic [31:0]      instr;
        logic             branch;
        logic [1:0]       cvalid;             // Commit slots
        areg_t [1:0]      careg;
        phreg_t [1:0]     cprd;
        phreg_t [1:0]     cold;
        logic             recover;
        checkpoint_t      rckp;
        logic             del;
        logic             rollback;
        phreg_t           e_prs1;             // Expected outputs
        phreg_t           e_prs2;
        phreg_t           e_prd;
        phreg_t           e_old;
        logic             e_stall;
        checkpoint_t      e_ckp;
    } row_t;

    logic            clk;
    logic            rstn;
    logic            rename_valid;
    logic [31:0]     instr;
    logic            is_branch;
    logic [1:0]      commit_valid;
    areg_t [1:0]     commit_areg;
    phreg_t [1:0]    commit_prd;
    phreg_t [1:0]    commit_old_prd;
    logic            recover;
    checkpoint_t     recover_checkpoint;
    logic            delete_checkpoint;
    logic            rollback;
    phreg_t          prs1;
    phreg_t          prs2;
    phreg_t          prd;
    phreg_t          old_prd;
    checkpoint_t     checkpoint;
    logic            stall;

    row_t            rows[$];
    row_t            cur;                      // Row under construction
    phreg_t          smap[`NUM_ISA_REGS];      // Shadow live map
    phreg_t          cmap[`NUM_ISA_REGS];      // Shadow committed map
    phreg_t          saved_map[`NUM_CHECKPOINTS][`NUM_ISA_REGS];
    phreg_t          free_order[$];            // Every register ever put on the list
    int              hd;                       // Next allocation in free_order
    int              saved_hd[`NUM_CHECKPOINTS];
    int              ver;                      // Live version
    int              tail_ver;                 // Oldest version
    int              nckp;                     // Live checkpoints
    checkpoint_t     ckp_label;                // Last label handed out

    rename_unit UUT (
        .clk_i                (clk),
        .rstn_i               (rstn),
        .rename_valid_i       (rename_valid),
        .instr_i              (instr),
        .is_branch_i          (is_branch),
        .commit_valid_i       (commit_valid),
        .commit_areg_i        (commit_areg),
        .commit_prd_i         (commit_prd),
        .commit_old_prd_i     (commit_old_prd),
        .recover_i            (recover),
        .recover_checkpoint_i (recover_checkpoint),
        .delete_checkpoint_i  (delete_checkpoint),
        .rollback_i           (rollback),
        .prs1_o               (prs1),
        .prs2_o               (prs2),
        .prd_o                (prd),
        .old_prd_o            (old_prd),
        .checkpoint_o         (checkpoint),
        .stall_o              (stall)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                // 20 ns period
    end

    initial begin
        rstn = 1'b0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
    end

    task automatic fail_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            fail_run();
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Row builders, each keeps the shadow state in step
    ////////////////////////////////////////////////////////////////////
    task automatic new_row();
        cur       = '0;
        cur.e_ckp = ckp_label;                 // Label from the previous row's branch
    endtask

    task automatic commit_slot(input int s, input int areg, input int cprd, input int cold);
        cur.cvalid[s] = 1'b1;
        cur.careg[s]  = areg_t'(areg);
        cur.cprd[s]   = phreg_t'(cprd);
        cur.cold[s]   = phreg_t'(cold);
        cmap[areg]    = phreg_t'(cprd);
        if (cold != 0) free_order.push_back(phreg_t'(cold)); // x0 is never freed
    endtask

    task automatic rename_row(input logic [6:0] opc, input int rd, input int rs1,
                              input int rs2, input logic br);
        logic       use1;
        logic       use2;
        logic       used;
        int         a1;
        int         a2;
        int         ad;
        logic [6:0] funct7;
        use1   = (opc == OPC_OP) || (opc == OPC_OP_IMM) || (opc == OPC_BRANCH);
        use2   = (opc == OPC_OP) || (opc == OPC_BRANCH);
        used   = ((opc == OPC_OP) || (opc == OPC_OP_IMM)) && (rd != 0);
        a1     = use1 ? rs1 : 0;
        a2     = use2 ? rs2 : 0;
        ad     = used ? rd : 0;
        funct7 = (opc == OPC_OP_IMM) ? 7'h5a : 7'h00;      // Immediate bits for I-type
        cur.valid   = 1'b1;
        cur.branch  = br;
        cur.instr   = {funct7, areg_t'(rs2), areg_t'(rs1), 3'b000, areg_t'(rd), opc};
        cur.e_prs1  = smap[a1];
        cur.e_prs2  = smap[a2];
        cur.e_old   = smap[ad];
        cur.e_stall = (used && hd == free_order.size())
                    || (br && nckp == `NUM_CHECKPOINTS - 1);
        if (!cur.e_stall) begin
            if (used) begin
                cur.e_prd = free_order[hd];
                smap[rd]  = free_order[hd];
                hd++;
            end
            if (br) begin
                for (int r = 0; r < `NUM_ISA_REGS; r++) saved_map[ver][r] = smap[r];
                saved_hd[ver] = hd;
                ckp_label     = checkpoint_t'(ver);         // Seen one row later
                ver           = (ver + 1) % `NUM_CHECKPOINTS;
                nckp++;
            end
        end
        rows.push_back(cur);
    endtask

    task automatic idle_row();
        rows.push_back(cur);                   // Opcode 0 reads x0 everywhere
    endtask

    task automatic recover_row(input int label);
        cur.recover = 1'b1;
        cur.rckp    = checkpoint_t'(label);
        for (int r = 0; r < `NUM_ISA_REGS; r++) smap[r] = saved_map[label][r];
        hd   = saved_hd[label];
        ver  = label;
        nckp = (label - tail_ver + `NUM_CHECKPOINTS) % `NUM_CHECKPOINTS;
        rows.push_back(cur);
    endtask

    task automatic delete_row();
        cur.del  = 1'b1;
        tail_ver = (tail_ver + 1) % `NUM_CHECKPOINTS;
        nckp--;
        rows.push_back(cur);
    endtask

    task automatic rollback_row();
        cur.rollback = 1'b1;
        for (int r = 0; r < `NUM_ISA_REGS; r++) smap[r] = cmap[r];
        hd        = free_order.size() - `FREE_LIST_ENTRIES; // Head to tail, list full
        ver       = 0;
        tail_ver  = 0;
        nckp      = 0;
        ckp_label = '0;
        rows.push_back(cur);
    endtask

    task automatic random_renames(input int n);
        int         rd;
        logic [6:0] opc;
        repeat (n) begin
            new_row();
            rd  = 1 + ($urandom % 31);         // Never x0
            opc = ($urandom % 2) ? OPC_OP : OPC_OP_IMM;
            rename_row(opc, rd, $urandom % 32, $urandom % 32, 1'b0);
        end
    endtask

    task automatic build_table();
        for (int r = 0; r < `NUM_ISA_REGS; r++) begin
            smap[r] = phreg_t'(r);             // Identity after reset
            cmap[r] = phreg_t'(r);
        end
        for (int p = `NUM_ISA_REGS; p < `NUM_PHYS_REGS; p++) free_order.push_back(phreg_t'(p));
        hd = 0; ver = 0; tail_ver = 0; nckp = 0; ckp_label = '0;
        // First allocations 32, 33, 34
        new_row(); rename_row(OPC_OP, 1, 2, 3, 1'b0);
        new_row(); rename_row(OPC_OP, 2, 1, 3, 1'b0);
        new_row(); rename_row(OPC_OP, 3, 1, 2, 1'b0);
        // x0 destination and I-type rs2 field
        new_row(); rename_row(OPC_OP, 0, 1, 2, 1'b0);
        new_row(); rename_row(OPC_OP_IMM, 4, 3, 31, 1'b0);
        new_row(); idle_row();
        // Branch, speculate past it, recover
        new_row(); rename_row(OPC_BRANCH, 10, 1, 2, 1'b1);
        new_row(); rename_row(OPC_OP, 1, 4, 3, 1'b0);
        new_row(); rename_row(OPC_OP, 5, 1, 0, 1'b0);
        new_row(); recover_row(0);
        new_row(); rename_row(OPC_OP, 6, 1, 5, 1'b0);
        // Refill by commit, drain the list, stall, then bypass a free
        new_row(); commit_slot(0, 1, 32, 1); commit_slot(1, 2, 33, 2); idle_row();
        random_renames(free_order.size() - hd);
        new_row(); rename_row(OPC_OP, 7, 1, 2, 1'b0);
        new_row(); rename_row(OPC_OP, 7, 1, 2, 1'b0);   // Held while stalled
        new_row(); commit_slot(0, 3, 34, 3); rename_row(OPC_OP, 7, 1, 2, 1'b0);
        // Run out of checkpoints, free one by delete
        repeat (4) begin
            new_row();
            rename_row(OPC_BRANCH, 10, 1, 2, 1'b1);
        end
        new_row(); delete_row();
        new_row(); rename_row(OPC_BRANCH, 10, 1, 2, 1'b1);
        new_row(); idle_row();
        // Exception rollback, full list again
        new_row(); rollback_row();
        new_row(); rename_row(OPC_OP, 8, 1, 2, 1'b0);
        new_row(); rename_row(OPC_OP, 9, 4, 3, 1'b0);
        random_renames(free_order.size() - hd);
        new_row(); rename_row(OPC_OP, 10, 1, 2, 1'b0);
        new_row(); idle_row();
    endtask

    ////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////
    initial begin
        int   n;
        int   seed;
        row_t r;
        rename_valid = 1'b0; instr = '0; is_branch = 1'b0;
        commit_valid = '0; commit_areg = '0; commit_prd = '0; commit_old_prd = '0;
        recover = 1'b0; recover_checkpoint = '0; delete_checkpoint = 1'b0; rollback = 1'b0;
        seed = $urandom(32'hf3574fb4);
        build_table();
        n = 0;
        while (rstn !== 1'b1 && n < RST_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rstn !== 1'b1) begin
            $display("Reset was not released within %0d cycles", RST_LIMIT);
            fail_run();
        end
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            @(posedge clk);
            rename_valid       <= r.valid;
            instr              <= r.instr;
            is_branch          <= r.branch;
            commit_valid       <= r.cvalid;
            commit_areg        <= r.careg;
            commit_prd         <= r.cprd;
            commit_old_prd     <= r.cold;
            recover            <= r.recover;
            recover_checkpoint <= r.rckp;
            delete_checkpoint  <= r.del;
            rollback           <= r.rollback;
            @(negedge clk);                    // Outputs settled mid-cycle
            check_value(prs1, r.e_prs1, $sformatf("row %0d prs1_o", i));
            check_value(prs2, r.e_prs2, $sformatf("row %0d prs2_o", i));
            check_value(prd, r.e_prd, $sformatf("row %0d prd_o", i));
            check_value(old_prd, r.e_old, $sformatf("row %0d old_prd_o", i));
            check_value(stall, r.e_stall, $sformatf("row %0d stall_o", i));
            check_value(checkpoint, r.e_ckp, $sformatf("row %0d checkpoint_o", i));
        end
        @(posedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/rename_unit.sv
//////////////////////////////////////////////////////////////////////
// Register rename stage top, decodes register use and forms the stall
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rename_unit (
    input  wire                                  clk_i,
    input  wire                                  rstn_i,
    input  wire                                  rename_valid_i,
    input  wire riscv_instr_pkg::instr_t         instr_i,
    input  wire                                  is_branch_i,       // Takes a checkpoint
    input  wire [1:0]                            commit_valid_i,
    input  wire rename_types_pkg::areg_t [1:0]   commit_areg_i,
    input  wire rename_types_pkg::phreg_t [1:0]  commit_prd_i,
    input  wire rename_types_pkg::phreg_t [1:0]  commit_old_prd_i,  // Returned to free list
    input  wire                                  recover_i,         // Mispredict
    input  wire rename_types_pkg::checkpoint_t   recover_checkpoint_i,
    input  wire                                  delete_checkpoint_i,
    input  wire                                  rollback_i,        // Exception
    output rename_types_pkg::phreg_t             prs1_o,
    output rename_types_pkg::phreg_t             prs2_o,
    output rename_types_pkg::phreg_t             prd_o,
    output rename_types_pkg::phreg_t             old_prd_o,
    output rename_types_pkg::checkpoint_t        checkpoint_o,
    output logic                                 stall_o
);
    import rename_types_pkg::*;
    import riscv_instr_pkg::*;

    logic [6:0] opcode;
    logic       rs1_used;
    logic       rs2_used;
    logic       needs_reg;     // Real destination, not x0
    logic       fl_empty;
    logic       out_of_ckp;
    logic       rename_fire;
    logic       alloc;
    logic       take_ckp;
    areg_t      rs1_idx;
    areg_t      rs2_idx;
    areg_t      rd_idx;
    phreg_t     new_prd;

    ////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////
    assign opcode   = instr_i.itype.opcode;
    assign rs1_used = (opcode == OPC_OP) | (opcode == OPC_OP_IMM) | (opcode == OPC_LOAD)
                    | (opcode == OPC_STORE) | (opcode == OPC_BRANCH);
    assign rs2_used = (opcode == OPC_OP) | (opcode == OPC_STORE) | (opcode == OPC_BRANCH);
    assign needs_reg = ((opcode == OPC_OP) | (opcode == OPC_OP_IMM) | (opcode == OPC_LOAD)
                     | (opcode == OPC_LUI) | (opcode == OPC_JAL)) & (instr_i.itype.rd != '0);

    // Unused fields read x0, which always maps to phys 0
    assign rs1_idx = rs1_used ? instr_i.itype.rs1 : '0;
    assign rs2_idx = rs2_used ? instr_i.rtype.rs2 : '0;   // I-type bits here are imm
    assign rd_idx  = needs_reg ? instr_i.itype.rd : '0;

    // Stall when a register or checkpoint is missing
    assign stall_o     = rename_valid_i & ((needs_reg & fl_empty) | (is_branch_i & out_of_ckp));
    assign rename_fire = rename_valid_i & ~stall_o;
    assign alloc       = rename_fire & needs_reg;
    assign take_ckp    = rename_fire & is_branch_i;
    assign prd_o       = alloc ? new_prd : '0;

    free_list free_list_inst (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .read_head_i          (alloc),
        .add_free_register_i  (commit_valid_i),
        .free_register_i      (commit_old_prd_i),
        .do_checkpoint_i      (take_ckp),
        .do_recover_i         (recover_i),
        .delete_checkpoint_i  (delete_checkpoint_i),
        .recover_checkpoint_i (recover_checkpoint_i),
        .commit_roll_back_i   (rollback_i),
        .new_register_o       (new_prd),
        .checkpoint_o         (checkpoint_o),
        .out_of_checkpoints_o (out_of_ckp),
        .empty_o              (fl_empty)
    );

    rename_table rename_table_inst (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .rs1_i                (rs1_idx),
        .rs2_i                (rs2_idx),
        .rd_i                 (rd_idx),
        .rename_i             (alloc),
        .new_prd_i            (new_prd),
        .do_checkpoint_i      (take_ckp),
        .do_recover_i         (recover_i),
        .recover_checkpoint_i (recover_checkpoint_i),
        .delete_checkpoint_i  (delete_checkpoint_i),
        .commit_i             (commit_valid_i),
        .commit_areg_i        (commit_areg_i),
        .commit_prd_i         (commit_prd_i),
        .rollback_i           (rollback_i),
        .prs1_o               (prs1_o),
        .prs2_o               (prs2_o),
        .old_prd_o            (old_prd_o)
    );

endmodule

`default_nettype wire

// File: design/rename_table.sv
//////////////////////////////////////////////////////////////////////
// Register map table, one speculative map per checkpoint plus the
// committed map used on exception rollback
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rename_settings.svh"

module rename_table (
    input  wire                                  clk_i,
    input  wire                                  rstn_i,
    input  wire rename_types_pkg::areg_t         rs1_i,
    input  wire rename_types_pkg::areg_t         rs2_i,
    input  wire rename_types_pkg::areg_t         rd_i,
    input  wire                                  rename_i,        // Write rd mapping
    input  wire rename_types_pkg::phreg_t        new_prd_i,
    input  wire                                  do_checkpoint_i,
    input  wire                                  do_recover_i,
    input  wire rename_types_pkg::checkpoint_t   recover_checkpoint_i,
    input  wire                                  delete_checkpoint_i,
    input  wire [1:0]                            commit_i,
    input  wire rename_types_pkg::areg_t [1:0]   commit_areg_i,
    input  wire rename_types_pkg::phreg_t [1:0]  commit_prd_i,
    input  wire                                  rollback_i,
    output rename_types_pkg::phreg_t             prs1_o,
    output rename_types_pkg::phreg_t             prs2_o,
    output rename_types_pkg::phreg_t             old_prd_o
);
    import rename_types_pkg::*;

    localparam int CKP_CNT_W = $clog2(`NUM_CHECKPOINTS) + 1;

    phreg_t               map_q [`NUM_CHECKPOINTS][`NUM_ISA_REGS]; // Speculative maps
    phreg_t               committed_q [`NUM_ISA_REGS];
    checkpoint_t          version_head_q;   // Tracks the free list versions
    checkpoint_t          version_tail_q;
    logic [CKP_CNT_W-1:0] num_ckp_q;

    logic                 write_rd;
    logic                 ckp_en;

    assign write_rd = rename_i & (rd_i != '0);        // x0 stays on phys 0
    assign ckp_en   = do_checkpoint_i & (num_ckp_q < CKP_CNT_W'(`NUM_CHECKPOINTS - 1))
                    & ~do_recover_i & ~rollback_i;

    // Lookups from the live map
    assign prs1_o    = map_q[version_head_q][rs1_i];
    assign prs2_o    = map_q[version_head_q][rs2_i];
    assign old_prd_o = map_q[version_head_q][rd_i];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int r = 0; r < `NUM_ISA_REGS; r++) begin
                for (int c = 0; c < `NUM_CHECKPOINTS; c++) begin
                    map_q[c][r] <= phreg_t'(r);      // Identity map
                end
                committed_q[r] <= phreg_t'(r);
            end
            version_head_q <= '0;
            version_tail_q <= '0;
            num_ckp_q      <= '0;
        end else begin
            //////////////////////////////////////////////////////////////
            // Committed map, second port wins on the same register
            //////////////////////////////////////////////////////////////
            if (commit_i[0]) begin
                committed_q[commit_areg_i[0]] <= commit_prd_i[0];
            end
            if (commit_i[1]) begin
                committed_q[commit_areg_i[1]] <= commit_prd_i[1];
            end

            if (rollback_i) begin
                for (int r = 0; r < `NUM_ISA_REGS; r++) begin
                    map_q[0][r] <= committed_q[r];
                end
                version_head_q <= '0;
                version_tail_q <= '0;
                num_ckp_q      <= '0;
            end else begin
                version_tail_q <= version_tail_q + checkpoint_t'(delete_checkpoint_i);

                if (do_recover_i) begin
                    version_head_q <= recover_checkpoint_i;
                    num_ckp_q      <= CKP_CNT_W'(checkpoint_t'(recover_checkpoint_i
                                                               - version_tail_q));
                end else begin
                    num_ckp_q <= num_ckp_q + CKP_CNT_W'(ckp_en)
                               - CKP_CNT_W'(delete_checkpoint_i);
                    if (write_rd) begin
                        map_q[version_head_q][rd_i] <= new_prd_i;
                    end

                    //////////////////////////////////////////////////////
                    // Snapshot includes this cycle's rd write
                    //////////////////////////////////////////////////////
                    if (ckp_en) begin
                        for (int r = 0; r < `NUM_ISA_REGS; r++) begin
                            map_q[version_head_q + 1'b1][r] <=
                                (write_rd && (rd_i == areg_t'(r))) ? new_prd_i
                                                                   : map_q[version_head_q][r];
                        end
                        version_head_q <= version_head_q + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/free_list.sv
//////////////////////////////////////////////////////////////////////
// Free list of physical registers, circular buffer with one head and
// count per checkpoint and a single shared tail
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rename_settings.svh"

module free_list (
    input  wire                                  clk_i,
    input  wire                                  rstn_i,
    input  wire                                  read_head_i,          // Take head register
    input  wire [1:0]                            add_free_register_i,  // Commit frees
    input  wire rename_types_pkg::phreg_t [1:0]  free_register_i,
    input  wire                                  do_checkpoint_i,
    input  wire                                  do_recover_i,
    input  wire                                  delete_checkpoint_i,  // Oldest one resolved
    input  wire rename_types_pkg::checkpoint_t   recover_checkpoint_i,
    input  wire                                  commit_roll_back_i,   // Exception
    output rename_types_pkg::phreg_t             new_register_o,
    output rename_types_pkg::checkpoint_t        checkpoint_o,
    output logic                                 out_of_checkpoints_o,
    output logic                                 empty_o
);
    import rename_types_pkg::*;

    localparam int PTR_W     = $clog2(`FREE_LIST_ENTRIES);
    localparam int CNT_W     = PTR_W + 1;                    // Must reach full count
    localparam int CKP_CNT_W = $clog2(`NUM_CHECKPOINTS) + 1;

    phreg_t               fifo_q  [`FREE_LIST_ENTRIES];
    logic [PTR_W-1:0]     head_q  [`NUM_CHECKPOINTS];      // Head per version
    logic [CNT_W-1:0]     count_q [`NUM_CHECKPOINTS];      // Free count per version
    logic [PTR_W-1:0]     tail_q;                          // Shared by all versions
    checkpoint_t          version_head_q;                  // Live version
    checkpoint_t          version_tail_q;                  // Oldest version
    logic [CKP_CNT_W-1:0] num_ckp_q;                       // Live checkpoints

    logic                 we0;
    logic                 we1;
    logic                 re;
    logic                 ckp_en;
    logic [1:0]           num_writes;
    logic [CNT_W-1:0]     live_count;

    assign live_count = count_q[version_head_q];

    // Frees go to every version, x0 is never freed
    assign we0 = add_free_register_i[0] & (free_register_i[0] != '0) & ~commit_roll_back_i;
    assign we1 = add_free_register_i[1] & (free_register_i[1] != '0) & ~commit_roll_back_i;
    assign num_writes = {1'b0, we0} + {1'b0, we1};

    // Read allowed when something is stored or bypassed this cycle
    assign re = read_head_i & ((live_count != '0) | we0 | we1)
              & ~do_recover_i & ~commit_roll_back_i;

    // One version always stays live, so at most N-1 checkpoints
    assign ckp_en = do_checkpoint_i & (num_ckp_q < CKP_CNT_W'(`NUM_CHECKPOINTS - 1))
                  & ~do_recover_i & ~commit_roll_back_i;

    always_comb begin
        if (!re) begin
            new_register_o = '0;
        end else if (live_count == '0) begin               // Empty, bypass a free
            new_register_o = we0 ? free_register_i[0] : free_register_i[1];
        end else begin
            new_register_o = fifo_q[head_q[version_head_q]];
        end
    end

    assign empty_o              = (live_count == '0) & ~we0 & ~we1;
    assign out_of_checkpoints_o = (num_ckp_q == CKP_CNT_W'(`NUM_CHECKPOINTS - 1));

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `FREE_LIST_ENTRIES; i++) begin
                fifo_q[i] <= phreg_t'(i + `NUM_ISA_REGS);  // Holds 32..63
            end
            for (int c = 0; c < `NUM_CHECKPOINTS; c++) begin
                head_q[c]  <= '0;
                count_q[c] <= CNT_W'(`FREE_LIST_COUNT_RST);
            end
            tail_q         <= '0;
            version_head_q <= '0;
            version_tail_q <= '0;
            num_ckp_q      <= '0;
            checkpoint_o   <= '0;
        end else if (commit_roll_back_i) begin
            // Drop all speculation, everything not committed is free again
            head_q[0]      <= tail_q;
            count_q[0]     <= CNT_W'(`FREE_LIST_COUNT_RST);
            version_head_q <= '0;
            version_tail_q <= '0;
            num_ckp_q      <= '0;
            checkpoint_o   <= '0;
        end else begin
            //////////////////////////////////////////////////////////////
            // Commit frees at the tail
            //////////////////////////////////////////////////////////////
            if (we0) begin
                fifo_q[tail_q] <= free_register_i[0];
            end
            if (we1) begin
                fifo_q[tail_q + PTR_W'(we0)] <= free_register_i[1]; // After slot 0 if used
            end
            tail_q         <= tail_q + PTR_W'(num_writes);
            version_tail_q <= version_tail_q + checkpoint_t'(delete_checkpoint_i);

            for (int c = 0; c < `NUM_CHECKPOINTS; c++) begin
                count_q[c] <= count_q[c] + CNT_W'(num_writes);
            end

            if (do_recover_i) begin
                // Versions between tail and the recovered one stay live
                version_head_q <= recover_checkpoint_i;
                num_ckp_q      <= CKP_CNT_W'(checkpoint_t'(recover_checkpoint_i
                                                           - version_tail_q));
            end else begin
                num_ckp_q <= num_ckp_q + CKP_CNT_W'(ckp_en) - CKP_CNT_W'(delete_checkpoint_i);

                // Allocation only counts against the live version
                head_q[version_head_q]  <= head_q[version_head_q] + PTR_W'(re);
                count_q[version_head_q] <= live_count + CNT_W'(num_writes) - CNT_W'(re);

                //////////////////////////////////////////////////////////
                // Checkpoint copies updated head and count forward
                //////////////////////////////////////////////////////////
                if (ckp_en) begin
                    head_q[version_head_q + 1'b1]  <= head_q[version_head_q] + PTR_W'(re);
                    count_q[version_head_q + 1'b1] <= live_count + CNT_W'(num_writes)
                                                    - CNT_W'(re);
                    version_head_q <= version_head_q + 1'b1;
                    checkpoint_o   <= version_head_q;       // Label to recover to
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/riscv_instr_pkg.sv
//////////////////////////////////////////////////////////////////////
// RISC-V instruction word with R-type and I-type field views
//////////////////////////////////////////////////////////////////////

`default_nettype none

package riscv_instr_pkg;

    typedef struct packed {
        logic [6:0]               funct7;
        rename_types_pkg::areg_t  rs2;
        rename_types_pkg::areg_t  rs1;
        logic [2:0]               funct3;
        rename_types_pkg::areg_t  rd;
        logic [6:0]               opcode;
    } rtype_t;

    typedef struct packed {
        logic [11:0]              imm12;   // Overlays funct7 and rs2
        rename_types_pkg::areg_t  rs1;
        logic [2:0]               funct3;
        rename_types_pkg::areg_t  rd;
        logic [6:0]               opcode;
    } itype_t;

    // Same 32-bit word, two decodings
    typedef union packed {
        rtype_t rtype;
        itype_t itype;
    } instr_t;

    ////////////////////////////////////////////////////////////////////
    // Major opcodes that decide source and destination use
    ////////////////////////////////////////////////////////////////////
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // rs1, rs2, rd
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // rs1, rd
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;  // rs1, rd
    localparam logic [6:0] OPC_STORE  = 7'b0100011;  // rs1, rs2
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;  // rs1, rs2
    localparam logic [6:0] OPC_LUI    = 7'b0110111;  // rd only
    localparam logic [6:0] OPC_JAL    = 7'b1101111;  // rd only

endpackage

`default_nettype wire

// File: design/rename_types_pkg.sv
//////////////////////////////////////////////////////////////////////
// Rename types: register indices and checkpoint labels
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "rename_settings.svh"

package rename_types_pkg;

    // Physical register index
    typedef logic [$clog2(`NUM_PHYS_REGS)-1:0] phreg_t;

    // Architectural register index, as found in the instruction word
    typedef logic [$clog2(`NUM_ISA_REGS)-1:0] areg_t;

    // Label of a map / free list version
    typedef logic [$clog2(`NUM_CHECKPOINTS)-1:0] checkpoint_t;

endpackage

`default_nettype wire

// File: design/rename_settings.svh
//////////////////////////////////////////////////////////////////////
// Rename stage settings
// Register counts, checkpoint versions and free list reset count
//////////////////////////////////////////////////////////////////////

`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

`define NUM_PHYS_REGS       64   // Physical register file size
`define NUM_ISA_REGS        32   // RISC-V integer registers

// Map and free list versions, one is always the live one
`define NUM_CHECKPOINTS     4

// Registers beyond the architectural ones start out free
`define FREE_LIST_ENTRIES   (`NUM_PHYS_REGS - `NUM_ISA_REGS)
`define FREE_LIST_COUNT_RST `FREE_LIST_ENTRIES

`endif
